/* hw/n64_io_pkg.sv */
// N64 I/O glue package with shared constants, enums and bus records
package n64_io_pkg;

	// ====================
	// Constants
	// ====================

	localparam logic [26:0] CART_GB_BASE      = 27'd8388608;
	localparam logic [7:0]  ANALOG_BIAS       = 8'd128;
	localparam logic [7:0]  LLAPI_TYPE_NONE   = 8'd0;
	localparam logic [7:0]  LLAPI_TYPE_SEARCH = 8'd255;

	localparam logic [11:0] AR_DEFAULT_X = 12'd4;
	localparam logic [11:0] AR_DEFAULT_Y = 12'd3;

	// Indexed by crop code, entry 0 is no crop
	localparam logic [2:0][11:0] AR_PAL_X  = {12'd2048, 12'd1024, 12'd512};
	localparam logic [2:0][11:0] AR_PAL_Y  = {12'd1419, 12'd731, 12'd387};
	localparam logic [2:0][11:0] AR_NTSC_X = {12'd2560, 12'd1280, 12'd512};
	localparam logic [2:0][11:0] AR_NTSC_Y = {12'd1714, 12'd889, 12'd381};

	// ====================
	// Enums
	// ====================

	typedef enum logic [5:0] {
		DL_PIFROM   = 6'd0,
		DL_CART_N64 = 6'd1,
		DL_CART_GB  = 6'd2
	} dl_kind_e;

	typedef enum logic [1:0] {ALLOC_NORMAL, ALLOC_B_ONLY, ALLOC_MUTED} alloc_e;
	typedef enum logic [1:0] {DUAL_OFF, DUAL_P1_P2, DUAL_P1_P3} dual_e;
	typedef enum logic [1:0] {CROP_NONE, CROP_8, CROP_12} crop_e;
	typedef enum logic [1:0] {AR_ORIGINAL, AR_FULL, AR_ARC1, AR_ARC2} ar_mode_e;

	// ====================
	// Records
	// ====================

	typedef struct packed {
		logic right, left, down, up;
		logic a, b, start;
		logic l, r, z;
		logic c_up, c_right, c_down, c_left;
		logic signed [7:0] stick_x;
		logic signed [7:0] stick_y;
	} pad_t;

	// slot[0] is player 1
	typedef struct packed {
		pad_t [3:0] slot;
	} pad_quad_t;

	typedef struct packed {
		logic [31:0] buttons;
		logic [7:0]  analog_x;
		logic [7:0]  analog_y;
		logic [7:0]  dev_type;
		logic        en;
	} llapi_rec_t;

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [26:0] addr;
		logic [15:0] dout;
		logic        wr;
	} ioctl_t;

	typedef struct packed {
		logic [9:0]  addr;
		logic [31:0] data;
		logic        wren;
	} pif_wr_t;

	typedef struct packed {
		logic [26:0] addr;
		logic [31:0] data;
		logic        req;
	} ram_wr_t;

	typedef struct packed {
		logic     pause;
		dual_e    dual;
		logic     is_pal;
		crop_e    crop;
		ar_mode_e ar_mode;
		logic     blanks_off;
		logic     clean_hdmi;
	} io_cfg_t;

endpackage

/* hw/llapi_pad_map.sv */
// Adapter pad decoder mapping one controller record to N64 pad layout
`timescale 1ns/1ps

module llapi_pad_map (
	input  n64_io_pkg::llapi_rec_t rec,
	output n64_io_pkg::pad_t       pad,
	output logic                   present
);
	import n64_io_pkg::*;

	logic [31:0] btn;

	assign btn = rec.buttons;

	// ====================
	// Button remap
	// ====================

	always_comb begin
		// D-pad sits in the upper byte of the HID word
		pad.right = btn[24];
		pad.left  = btn[25];
		pad.down  = btn[26];
		pad.up    = btn[27];

		pad.a     = btn[1];
		pad.b     = btn[0];
		pad.start = btn[5];

		pad.l     = btn[6];
		pad.r     = btn[7];
		pad.z     = btn[4];

		// C buttons
		pad.c_up    = btn[8];
		pad.c_right = btn[9];
		pad.c_down  = btn[3];
		pad.c_left  = btn[2];

		// Recenter unsigned axes around zero
		pad.stick_x = rec.analog_x - ANALOG_BIAS;
		pad.stick_y = rec.analog_y - ANALOG_BIAS;
	end

	// ====================
	// Presence
	// ====================

	// Type 0 covers both no pad and unsupported pads, 255 is the search state
	assign present = rec.en &&
			(rec.dev_type != LLAPI_TYPE_NONE) &&
			(rec.dev_type != LLAPI_TYPE_SEARCH);

endmodule

/* hw/pad_allocator.sv */
// Player slot allocator for adapter and USB pads with pause muting
`timescale 1ns/1ps

module pad_allocator (
	input  logic                  clk_1x,
	input  logic                  RESET,
	input  n64_io_pkg::pad_t      ll_a,
	input  n64_io_pkg::pad_t      ll_b,
	input  logic                  ll_a_present,
	input  logic                  ll_b_present,
	input  logic [31:0]           ll_a_raw,
	input  logic [31:0]           ll_b_raw,
	input  n64_io_pkg::pad_quad_t usb_pads,
	input  n64_io_pkg::io_cfg_t   cfg,
	output n64_io_pkg::pad_quad_t pads,
	output logic                  osd_request
);
	import n64_io_pkg::*;

	alloc_e    mode;
	pad_quad_t sel;
	pad_quad_t remap;
	logic      osd_next;

	// Lone B adapter wins even over pause
	always_comb begin
		if (!ll_a_present && ll_b_present) begin
			mode = ALLOC_B_ONLY;
		end else if (cfg.pause) begin
			mode = ALLOC_MUTED;
		end else begin
			mode = ALLOC_NORMAL;
		end
	end

	always_comb begin
		sel = '0;
		case (mode)
			ALLOC_B_ONLY: begin
				sel.slot[0] = ll_b;
				sel.slot[1] = usb_pads.slot[0];
				sel.slot[2] = usb_pads.slot[1];
				sel.slot[3] = usb_pads.slot[2];
			end
			ALLOC_NORMAL: begin
				sel.slot[0] = ll_a;
				sel.slot[1] = ll_b;
				sel.slot[2] = usb_pads.slot[0];
				sel.slot[3] = usb_pads.slot[1];
			end
			default: sel = '0;
		endcase
	end

	// Dual controller: P1 C-right drives Z of the paired slots
	always_comb begin
		remap = sel;
		remap.slot[1].z = (cfg.dual == DUAL_P1_P2) ? sel.slot[0].c_right : sel.slot[1].z;
		remap.slot[2].z = (cfg.dual == DUAL_P1_P3) ? sel.slot[0].c_right : sel.slot[2].z;
		remap.slot[3].z = (cfg.dual == DUAL_P1_P2) ? sel.slot[2].c_right :
				(cfg.dual == DUAL_P1_P3) ? sel.slot[1].c_right : sel.slot[3].z;
	end

	// Down + Start + B on either adapter opens the OSD
	assign osd_next = (ll_a_raw[26] & ll_a_raw[5] & ll_a_raw[0]) |
			(ll_b_raw[26] & ll_b_raw[5] & ll_b_raw[0]);

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pads        <= '0;
			osd_request <= 1'b0;
		end else begin
			pads        <= remap;
			osd_request <= osd_next;
		end
	end

	a_muted_zero: assert property (@(posedge clk_1x) disable iff (!RESET)
			(mode == ALLOC_MUTED) |=> (pads == '0));

endmodule

/* hw/pifrom_packer.sv */
// Boot ROM download packer building byte-swapped 32-bit words
`timescale 1ns/1ps

module pifrom_packer (
	input  logic                clk_1x,
	input  logic                RESET,
	input  n64_io_pkg::ioctl_t  ioctl,
	output n64_io_pkg::pif_wr_t pif_wr
);
	import n64_io_pkg::*;

	logic        pif_sel;
	logic [9:0]  wr_addr;
	logic [31:0] wr_data;
	logic        wren;

	assign pif_sel = ioctl.download && (ioctl.index[5:0] == DL_PIFROM);

	// Word payload, address taken on the even halfword
	always_ff @(posedge clk_1x) begin
		if (pif_sel && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				wr_data[31:24] <= ioctl.dout[7:0];
				wr_data[23:16] <= ioctl.dout[15:8];
				wr_addr        <= {ioctl.index[6], ioctl.addr[10:2]};
			end else begin
				wr_data[15:8] <= ioctl.dout[7:0];
				wr_data[7:0]  <= ioctl.dout[15:8];
			end
		end
	end

	// Odd halfword completes the word
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			wren <= 1'b0;
		end else begin
			wren <= pif_sel && ioctl.wr && ioctl.addr[1];
		end
	end

	assign pif_wr.addr = wr_addr;
	assign pif_wr.data = wr_data;
	assign pif_wr.wren = wren;

	a_wren_single: assert property (@(posedge clk_1x) disable iff (!RESET)
			pif_wr.wren |=> !pif_wr.wren);

endmodule

/* hw/cart_download_ctrl.sv */
// Cartridge download control for N64 ROM tracking and Game Boy RAM writes
`timescale 1ns/1ps

module cart_download_ctrl (
	input  logic                clk_1x,
	input  logic                RESET,
	input  n64_io_pkg::ioctl_t  ioctl,
	input  logic                ram_ready,
	output n64_io_pkg::ram_wr_t ram_wr,
	output logic                ioctl_wait,
	output logic                cart_loaded,
	output logic                romcopy_start,
	output logic [26:0]         romcopy_size,
	output logic                dl_active
);
	import n64_io_pkg::*;

	logic        n64_sel;
	logic        gb_sel;
	logic        download_q;
	logic [26:0] ram_addr;
	logic [31:0] ram_data;
	logic        ram_req;

	assign n64_sel = ioctl.download && (ioctl.index[5:0] == DL_CART_N64);
	assign gb_sel  = ioctl.download && (ioctl.index[5:0] == DL_CART_GB);

	// ====================
	// N64 cartridge
	// ====================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			download_q    <= 1'b0;
			cart_loaded   <= 1'b0;
			romcopy_start <= 1'b0;
			dl_active     <= 1'b0;
		end else begin
			download_q    <= ioctl.download;
			dl_active     <= n64_sel || gb_sel;
			romcopy_start <= 1'b0;
			if (n64_sel) begin
				cart_loaded <= 1'b1;
			end
			// Final address of the stream is the ROM size
			if (!ioctl.download && download_q && (ioctl.index[5:0] == DL_CART_N64)) begin
				romcopy_start <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!ioctl.download && download_q && (ioctl.index[5:0] == DL_CART_N64)) begin
			romcopy_size <= ioctl.addr;
		end
	end

	// ====================
	// Game Boy cartridge
	// ====================

	always_ff @(posedge clk_1x) begin
		if (gb_sel && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				ram_data[15:0] <= ioctl.dout;
				ram_addr       <= ioctl.addr + CART_GB_BASE;
			end else begin
				ram_data[31:16] <= ioctl.dout;
			end
		end
	end

	// Host stalls on wait until the RAM acknowledges the word
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			ram_req    <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			ram_req <= 1'b0;
			if (gb_sel) begin
				if (ioctl.wr && ioctl.addr[1]) begin
					ram_req    <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				if (ram_ready) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	assign ram_wr.addr = ram_addr;
	assign ram_wr.data = ram_data;
	assign ram_wr.req  = ram_req;

	a_req_with_wait: assert property (@(posedge clk_1x) disable iff (!RESET)
			$rose(ram_wr.req) |-> $rose(ioctl_wait));

	a_host_honors_wait: assert property (@(posedge clk_1x) disable iff (!RESET)
			ioctl_wait |-> !ioctl.wr);

endmodule

/* hw/aspect_ratio_sel.sv */
// Video aspect ratio selector from region, crop and user mode
`timescale 1ns/1ps

module aspect_ratio_sel (
	input  logic                clk_1x,
	input  logic                RESET,
	input  n64_io_pkg::io_cfg_t cfg,
	output logic [12:0]         video_arx,
	output logic [12:0]         video_ary
);
	import n64_io_pkg::*;

	logic [11:0] core_x;
	logic [11:0] core_y;
	logic [1:0]  mode_m1;

	// Core ratio follows the visible area of the VI
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= AR_DEFAULT_X;
			core_y <= AR_DEFAULT_Y;
		end else if (cfg.blanks_off || cfg.clean_hdmi) begin
			core_x <= AR_DEFAULT_X;
			core_y <= AR_DEFAULT_Y;
		end else if (cfg.crop inside {CROP_NONE, CROP_8, CROP_12}) begin
			if (cfg.is_pal) begin
				core_x <= AR_PAL_X[cfg.crop];
				core_y <= AR_PAL_Y[cfg.crop];
			end else begin
				core_x <= AR_NTSC_X[cfg.crop];
				core_y <= AR_NTSC_Y[cfg.crop];
			end
		end
	end

	// Non-original modes pass a scaler code instead of a ratio
	assign mode_m1 = cfg.ar_mode - 2'd1;

	always_comb begin
		if (cfg.ar_mode == AR_ORIGINAL) begin
			video_arx = {1'b0, core_x};
			video_ary = {1'b0, core_y};
		end else begin
			video_arx = {11'd0, mode_m1};
			video_ary = 13'd0;
		end
	end

endmodule

/* hw/n64_io_top.sv */
// N64 I/O glue top level connecting pads, downloads and aspect ratio
`timescale 1ns/1ps

module n64_io_top (
	input  logic                  clk_1x,
	input  logic                  RESET,
	input  n64_io_pkg::llapi_rec_t llapi_a,
	input  n64_io_pkg::llapi_rec_t llapi_b,
	input  n64_io_pkg::pad_quad_t usb_pads,
	input  n64_io_pkg::io_cfg_t   cfg,
	input  n64_io_pkg::ioctl_t    ioctl,
	input  logic                  ram_ready,
	output n64_io_pkg::pad_quad_t pads,
	output logic                  osd_request,
	output n64_io_pkg::pif_wr_t   pif_wr,
	output n64_io_pkg::ram_wr_t   ram_wr,
	output logic                  ioctl_wait,
	output logic                  cart_loaded,
	output logic                  romcopy_start,
	output logic [26:0]           romcopy_size,
	output logic                  dl_active,
	output logic [12:0]           video_arx,
	output logic [12:0]           video_ary
);
	import n64_io_pkg::*;

	pad_t pad_a;
	pad_t pad_b;
	logic present_a;
	logic present_b;

	// ====================
	// Pads
	// ====================

	llapi_pad_map u_map_a (.rec(llapi_a), .pad(pad_a), .present(present_a));
	llapi_pad_map u_map_b (.rec(llapi_b), .pad(pad_b), .present(present_b));

	pad_allocator u_pad_allocator (
		.clk_1x       (clk_1x),
		.RESET        (RESET),
		.ll_a         (pad_a),
		.ll_b         (pad_b),
		.ll_a_present (present_a),
		.ll_b_present (present_b),
		.ll_a_raw     (llapi_a.buttons),
		.ll_b_raw     (llapi_b.buttons),
		.usb_pads     (usb_pads),
		.cfg          (cfg),
		.pads         (pads),
		.osd_request  (osd_request)
	);

	// ====================
	// Downloads
	// ====================

	pifrom_packer u_pifrom_packer (.clk_1x(clk_1x), .RESET(RESET), .ioctl(ioctl), .pif_wr(pif_wr));

	cart_download_ctrl u_cart_download_ctrl (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.ram_ready     (ram_ready),
		.ram_wr        (ram_wr),
		.ioctl_wait    (ioctl_wait),
		.cart_loaded   (cart_loaded),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.dl_active     (dl_active)
	);

	aspect_ratio_sel u_aspect_ratio_sel (
		.clk_1x    (clk_1x),
		.RESET     (RESET),
		.cfg       (cfg),
		.video_arx (video_arx),
		.video_ary (video_ary)
	);

endmodule

/* verif/tb_n64_io.sv */
// Self-checking testbench for the N64 I/O glue with a reference model and a RAM responder
`timescale 1ns/1ps

module tb_n64_io;
	import n64_io_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int PAD_CYCLES   = 200;
	localparam int ALLOC_CYCLES = 40;
	localparam int DUAL_CYCLES  = 90;
	localparam int PIF_HALVES   = 64;
	localparam int GB_HALVES    = 32;
	localparam int N64_HALVES   = 40;
	localparam int AR_COMBOS    = 128;
	// Strobe plus gap, and for Game Boy the worst RAM answer on top
	localparam int MAX_CYCLES = RESET_CYCLES + PAD_CYCLES + ALLOC_CYCLES + DUAL_CYCLES +
			3 * PIF_HALVES + 13 * GB_HALVES + 3 * N64_HALVES + 2 * AR_COMBOS + 200;

	logic        clk_1x;
	logic        RESET;
	llapi_rec_t  llapi_a;
	llapi_rec_t  llapi_b;
	pad_quad_t   usb_pads;
	io_cfg_t     cfg;
	ioctl_t      ioctl;
	logic        ram_ready;
	pad_quad_t   pads;
	logic        osd_request;
	pif_wr_t     pif_wr;
	ram_wr_t     ram_wr;
	logic        ioctl_wait;
	logic        cart_loaded;
	logic        romcopy_start;
	logic [26:0] romcopy_size;
	logic        dl_active;
	logic [12:0] video_arx;
	logic [12:0] video_ary;

	logic [31:0] rng;
	int          errors;
	int          checks;
	int          tests_run;
	int          errors_mark;
	int          checks_mark;
	int          cycle_count;
	int          ram_writes_seen;
	int          romcopy_seen;

	// Reference state
	logic [31:0] pif_data_ref;
	logic [9:0]  pif_addr_ref;
	logic [31:0] ram_data_ref;
	logic [26:0] ram_addr_ref;
	logic        wait_ref;
	logic        prev_dl;
	logic        loaded_ref;
	logic [26:0] size_ref;
	logic [11:0] core_x_ref;
	logic [11:0] core_y_ref;

	n64_io_top dut (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.llapi_a       (llapi_a),
		.llapi_b       (llapi_b),
		.usb_pads      (usb_pads),
		.cfg           (cfg),
		.ioctl         (ioctl),
		.ram_ready     (ram_ready),
		.pads          (pads),
		.osd_request   (osd_request),
		.pif_wr        (pif_wr),
		.ram_wr        (ram_wr),
		.ioctl_wait    (ioctl_wait),
		.cart_loaded   (cart_loaded),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.dl_active     (dl_active),
		.video_arx     (video_arx),
		.video_ary     (video_ary)
	);

	initial clk_1x = 1'b0;
	always #2 clk_1x = ~clk_1x;

	// ====================
	// Reference functions
	// ====================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic pad_t map_pad(input llapi_rec_t rec);
		pad_t p;
		p.right   = rec.buttons[24];
		p.left    = rec.buttons[25];
		p.down    = rec.buttons[26];
		p.up      = rec.buttons[27];
		p.a       = rec.buttons[1];
		p.b       = rec.buttons[0];
		p.start   = rec.buttons[5];
		p.l       = rec.buttons[6];
		p.r       = rec.buttons[7];
		p.z       = rec.buttons[4];
		p.c_up    = rec.buttons[8];
		p.c_right = rec.buttons[9];
		p.c_down  = rec.buttons[3];
		p.c_left  = rec.buttons[2];
		p.stick_x = rec.analog_x - 8'd128;
		p.stick_y = rec.analog_y - 8'd128;
		return p;
	endfunction

	function automatic logic pad_present(input llapi_rec_t rec);
		return rec.en && (rec.dev_type != 8'd0) && (rec.dev_type != 8'd255);
	endfunction

	function automatic pad_quad_t alloc_ref(input llapi_rec_t ra, input llapi_rec_t rb,
			input pad_quad_t usb, input io_cfg_t c);
		pad_quad_t q;
		pad_quad_t r;
		q = '0;
		if (!pad_present(ra) && pad_present(rb)) begin
			q.slot[0] = map_pad(rb);
			q.slot[1] = usb.slot[0];
			q.slot[2] = usb.slot[1];
			q.slot[3] = usb.slot[2];
		end else if (!c.pause) begin
			q.slot[0] = map_pad(ra);
			q.slot[1] = map_pad(rb);
			q.slot[2] = usb.slot[0];
			q.slot[3] = usb.slot[1];
		end
		r = q;
		if (c.dual == DUAL_P1_P2) begin
			r.slot[1].z = q.slot[0].c_right;
			r.slot[3].z = q.slot[2].c_right;
		end else if (c.dual == DUAL_P1_P3) begin
			r.slot[2].z = q.slot[0].c_right;
			r.slot[3].z = q.slot[1].c_right;
		end
		return r;
	endfunction

	// Down, Start and B held together
	function automatic logic osd_ref(input logic [31:0] raw_a, input logic [31:0] raw_b);
		return (raw_a[26] && raw_a[5] && raw_a[0]) || (raw_b[26] && raw_b[5] && raw_b[0]);
	endfunction

	function automatic logic [15:0] swap_bytes(input logic [15:0] h);
		return {h[7:0], h[15:8]};
	endfunction

	function automatic logic [9:0] pif_word_addr(input logic [7:0] idx, input logic [26:0] a);
		return {idx[6], a[10:2]};
	endfunction

	function automatic logic [26:0] gb_ram_addr(input logic [26:0] a);
		return a + 27'd8388608;
	endfunction

	function automatic logic [23:0] ar_table_ref(input logic pal, input logic [1:0] crop);
		case ({pal, crop})
			3'b100:  return {12'd512, 12'd387};
			3'b101:  return {12'd1024, 12'd731};
			3'b110:  return {12'd2048, 12'd1419};
			3'b000:  return {12'd512, 12'd381};
			3'b001:  return {12'd1280, 12'd889};
			default: return {12'd2560, 12'd1714};
		endcase
	endfunction

	task automatic report_mismatch(input string sig, input logic [127:0] exp_v,
			input logic [127:0] got_v);
		errors++;
		$display("[ERROR] %s expected 0x%0h got 0x%0h at %0t", sig, exp_v, got_v, $time);
	endtask

	// ====================
	// Comparison process
	// ====================

	always @(posedge clk_1x) begin
		pad_quad_t   exp_pads;
		logic        exp_osd;
		logic        n64_sel;
		logic        gb_sel;
		logic        pif_sel;
		logic        exp_wren;
		logic        exp_req;
		logic        exp_start;
		logic        exp_active;
		logic [23:0] ar;
		logic [12:0] exp_arx;
		logic [12:0] exp_ary;
		#1;
		if (!RESET) begin
			wait_ref   = 1'b0;
			prev_dl    = 1'b0;
			loaded_ref = 1'b0;
			core_x_ref = 12'd4;
			core_y_ref = 12'd3;
		end else begin
			checks++;
			n64_sel = ioctl.download && (ioctl.index[5:0] == 6'd1);
			gb_sel  = ioctl.download && (ioctl.index[5:0] == 6'd2);
			pif_sel = ioctl.download && (ioctl.index[5:0] == 6'd0);

			exp_pads = alloc_ref(llapi_a, llapi_b, usb_pads, cfg);
			exp_osd  = osd_ref(llapi_a.buttons, llapi_b.buttons);
			if (pads !== exp_pads) report_mismatch("pads", exp_pads, pads);
			if (osd_request !== exp_osd) report_mismatch("osd_request", exp_osd, osd_request);

			// Boot ROM word assembly
			if (pif_sel && ioctl.wr && !ioctl.addr[1]) begin
				pif_data_ref[31:16] = swap_bytes(ioctl.dout);
				pif_addr_ref        = pif_word_addr(ioctl.index, ioctl.addr);
			end
			exp_wren = pif_sel && ioctl.wr && ioctl.addr[1];
			if (exp_wren) pif_data_ref[15:0] = swap_bytes(ioctl.dout);
			if (pif_wr.wren !== exp_wren) report_mismatch("pif_wr.wren", exp_wren, pif_wr.wren);
			if (exp_wren && pif_wr.addr !== pif_addr_ref)
				report_mismatch("pif_wr.addr", pif_addr_ref, pif_wr.addr);
			if (exp_wren && pif_wr.data !== pif_data_ref)
				report_mismatch("pif_wr.data", pif_data_ref, pif_wr.data);

			// Game Boy RAM writes and the wait flag
			if (gb_sel && ioctl.wr && !ioctl.addr[1]) begin
				ram_data_ref[15:0] = ioctl.dout;
				ram_addr_ref       = gb_ram_addr(ioctl.addr);
			end
			exp_req = gb_sel && ioctl.wr && ioctl.addr[1];
			if (exp_req) ram_data_ref[31:16] = ioctl.dout;
			if (!gb_sel) begin
				wait_ref = 1'b0;
			end else begin
				if (exp_req) wait_ref = 1'b1;
				if (ram_ready) wait_ref = 1'b0;
			end
			if (ram_wr.req) ram_writes_seen++;
			if (ram_wr.req !== exp_req) report_mismatch("ram_wr.req", exp_req, ram_wr.req);
			if (exp_req && ram_wr.addr !== ram_addr_ref)
				report_mismatch("ram_wr.addr", ram_addr_ref, ram_wr.addr);
			if (exp_req && ram_wr.data !== ram_data_ref)
				report_mismatch("ram_wr.data", ram_data_ref, ram_wr.data);
			if (ioctl_wait !== wait_ref) report_mismatch("ioctl_wait", wait_ref, ioctl_wait);

			// N64 cartridge tracking
			exp_start = !ioctl.download && prev_dl && (ioctl.index[5:0] == 6'd1);
			if (exp_start) size_ref = ioctl.addr;
			prev_dl = ioctl.download;
			if (n64_sel) loaded_ref = 1'b1;
			exp_active = n64_sel || gb_sel;
			if (romcopy_start) romcopy_seen++;
			if (romcopy_start !== exp_start)
				report_mismatch("romcopy_start", exp_start, romcopy_start);
			if (exp_start && romcopy_size !== size_ref)
				report_mismatch("romcopy_size", size_ref, romcopy_size);
			if (cart_loaded !== loaded_ref) report_mismatch("cart_loaded", loaded_ref, cart_loaded);
			if (dl_active !== exp_active) report_mismatch("dl_active", exp_active, dl_active);

			// Crop code 3 keeps the last aspect ratio
			if (cfg.blanks_off || cfg.clean_hdmi) begin
				core_x_ref = 12'd4;
				core_y_ref = 12'd3;
			end else if (cfg.crop != 2'd3) begin
				ar         = ar_table_ref(cfg.is_pal, cfg.crop);
				core_x_ref = ar[23:12];
				core_y_ref = ar[11:0];
			end
			if (cfg.ar_mode == AR_ORIGINAL) begin
				exp_arx = {1'b0, core_x_ref};
				exp_ary = {1'b0, core_y_ref};
			end else begin
				exp_arx = 13'(cfg.ar_mode) - 13'd1;
				exp_ary = 13'd0;
			end
			if (video_arx !== exp_arx) report_mismatch("video_arx", exp_arx, video_arx);
			if (video_ary !== exp_ary) report_mismatch("video_ary", exp_ary, video_ary);
		end
	end

	// RAM answers each request after 1 to 8 cycles
	initial begin
		int unsigned delay;
		forever begin
			@(posedge clk_1x);
			#1;
			if (RESET && ram_wr.req) begin
				delay = 1 + (rand32() % 8);
				repeat (delay) @(negedge clk_1x);
				ram_ready = 1'b1;
				@(negedge clk_1x);
				ram_ready = 1'b0;
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_1x);
			cycle_count++;
		end
		$display("Run hung: no finish after %0d cycles", MAX_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	// ====================
	// Stimulus
	// ====================

	task automatic random_record(output llapi_rec_t rec, input logic allow_absent);
		logic [31:0] r;
		r = rand32();
		rec.buttons  = rand32();
		rec.analog_x = r[7:0];
		rec.analog_y = r[15:8];
		rec.en       = !(allow_absent && r[22:19] == 4'd0);
		if (allow_absent && r[18:16] == 3'd0) begin
			rec.dev_type = 8'd0;
		end else if (allow_absent && r[18:16] == 3'd1) begin
			rec.dev_type = 8'd255;
		end else begin
			rec.dev_type = {1'b0, r[30:24]} | 8'd1;
		end
	endtask

	task automatic randomize_pads(input logic allow_absent);
		logic [127:0] u;
		random_record(llapi_a, allow_absent);
		random_record(llapi_b, allow_absent);
		u = {rand32(), rand32(), rand32(), rand32()};
		usb_pads = u[119:0];
	endtask

	task automatic write_halfword(input logic [26:0] a, input logic [15:0] d);
		ioctl.addr = a;
		ioctl.dout = d;
		ioctl.wr   = 1'b1;
		@(negedge clk_1x);
		ioctl.wr = 1'b0;
		repeat (rand32() % 3) @(negedge clk_1x);
		// Host stall while the RAM is busy
		while (ioctl_wait) @(negedge clk_1x);
	endtask

	task automatic run_download(input logic [7:0] idx, input logic [26:0] base, input int halves);
		ioctl.download = 1'b1;
		ioctl.index    = idx;
		@(negedge clk_1x);
		for (int i = 0; i < halves; i++) begin
			write_halfword(base + 27'(2 * i), 16'(rand32()));
		end
		ioctl.download = 1'b0;
		repeat (3) @(negedge clk_1x);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("test %-10s %0d cycles checked, %0d errors", name, checks - checks_mark,
				errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	initial begin
		int writes_mark;
		rng = 32'hc8ce;
		errors = 0;
		checks = 0;
		tests_run = 0;
		errors_mark = 0;
		checks_mark = 0;
		ram_writes_seen = 0;
		romcopy_seen = 0;
		RESET = 1'b0;
		llapi_a = '0;
		llapi_b = '0;
		usb_pads = '0;
		cfg = '0;
		ioctl = '0;
		ram_ready = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_1x);
		RESET = 1'b1;

		for (int i = 0; i < PAD_CYCLES; i++) begin
			randomize_pads(1'b1);
			@(negedge clk_1x);
		end
		finish_test("pad_map");

		cfg.pause = 1'b1;
		for (int i = 0; i < ALLOC_CYCLES; i++) begin
			randomize_pads(1'b0);
			if (i < ALLOC_CYCLES / 2) llapi_a.en = 1'b0;
			@(negedge clk_1x);
		end
		cfg.pause = 1'b0;
		finish_test("allocation");

		for (int d = 0; d < 3; d++) begin
			cfg.dual = dual_e'(d);
			for (int i = 0; i < DUAL_CYCLES / 3; i++) begin
				randomize_pads(1'b0);
				@(negedge clk_1x);
			end
		end
		cfg.dual = DUAL_OFF;
		finish_test("dual_z");

		run_download(8'h40, 27'(rand32() & 32'h7fc), PIF_HALVES);
		finish_test("boot_rom");

		writes_mark = ram_writes_seen;
		run_download(8'h02, 27'd0, GB_HALVES);
		if (ram_writes_seen - writes_mark != GB_HALVES / 2) begin
			errors++;
			$display("Game Boy download gave %0d RAM writes instead of %0d",
					ram_writes_seen - writes_mark, GB_HALVES / 2);
		end
		run_download(8'h01, 27'd0, N64_HALVES);
		if (romcopy_seen != 1) begin
			errors++;
			$display("ROM copy start pulsed %0d times after the N64 download", romcopy_seen);
		end
		finish_test("cartridge");

		for (int c = 0; c < AR_COMBOS; c++) begin
			cfg.is_pal     = c[0];
			cfg.crop       = crop_e'(c[2:1]);
			cfg.ar_mode    = ar_mode_e'(c[4:3]);
			cfg.blanks_off = c[5];
			cfg.clean_hdmi = c[6];
			repeat (2) @(negedge clk_1x);
		end
		finish_test("aspect");

		$display("summary: %0d tests, %0d cycles checked, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* filelist.f */
hw/n64_io_pkg.sv
hw/llapi_pad_map.sv
hw/pad_allocator.sv
hw/pifrom_packer.sv
hw/cart_download_ctrl.sv
hw/aspect_ratio_sel.sv
hw/n64_io_top.sv
verif/tb_n64_io.sv
